/* Makefile */
VERILATOR  ?= verilator
TOP        ?= link_model_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
FAIL_MSG   ?= STATUS: FAIL
PASS_MSG   ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/fwft_fifo.sv */
`timescale 1ns/1ps

module fwft_fifo
    import link_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  logic [ENTRY_WIDTH-1:0] din,
    output logic                   full,
    input  logic                   rd_en,
    output logic [ENTRY_WIDTH-1:0] dout,
    output logic                   empty
);

    // storage has no reset, only the pointers and count do
    logic [ENTRY_WIDTH-1:0] mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;

    assign full  = (count == COUNT_WIDTH'(FIFO_DEPTH));
    assign empty = (count == '0);

    // head entry always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count unchanged
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the lane must gate its pushes with full
    assert_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !full
    ) else $error("fwft_fifo: write while full");

    // and its pops with empty
    assert_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> !empty
    ) else $error("fwft_fifo: read while empty");

endmodule

/* hw/latency_lane.sv */
`timescale 1ns/1ps

module latency_lane
    import link_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [TIME_WIDTH-1:0] now,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   push;
    logic                   pop;
    logic [TIME_WIDTH-1:0]  release_time;
    logic [TIME_WIDTH-1:0]  head_time;
    logic [TIME_WIDTH-1:0]  head_age;
    logic [ENTRY_WIDTH-1:0] head_entry;

    assign in_ready = !fifo_full;
    assign push     = in_valid && in_ready;

    // stamp taken at acceptance
    assign release_time = now + TIME_WIDTH'(STAMP_OFFSET);

    assign out_data  = head_entry[ENTRY_WIDTH-1:TIME_WIDTH];
    assign head_time = head_entry[TIME_WIDTH-1:0];

    // sign bit set means the head stamp is still ahead of now
    assign head_age  = now - head_time;
    assign out_valid = !fifo_empty && !head_age[TIME_WIDTH-1];

    assign pop = out_valid && out_ready;

    fwft_fifo u_fifo (
        .clk   (clk),
        .reset (reset),
        .wr_en (push),
        .din   ({in_data, release_time}),
        .full  (fifo_full),
        .rd_en (pop),
        .dout  (head_entry),
        .empty (fifo_empty)
    );

    // a stalled head word must hold: the FIFO head pointer and the release
    // stamp together keep both valid and data steady until the handshake
    assert_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("latency_lane: head word changed under back-pressure");

endmodule

/* hw/link_model.sv */
`timescale 1ns/1ps

module link_model
    import link_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    // upstream board
    input  logic [BUS_WIDTH-1:0] up_in_data,
    input  logic [CHANNELS-1:0]  up_in_valid,
    output logic [CHANNELS-1:0]  up_in_ready,
    output logic [BUS_WIDTH-1:0] up_out_data,
    output logic [CHANNELS-1:0]  up_out_valid,
    input  logic [CHANNELS-1:0]  up_out_ready,

    // downstream board
    input  logic [BUS_WIDTH-1:0] dn_in_data,
    input  logic [CHANNELS-1:0]  dn_in_valid,
    output logic [CHANNELS-1:0]  dn_in_ready,
    output logic [BUS_WIDTH-1:0] dn_out_data,
    output logic [CHANNELS-1:0]  dn_out_valid,
    input  logic [CHANNELS-1:0]  dn_out_ready,

    // sideband status, downstream to upstream only
    input  logic [CHANNELS-1:0]  dn_msg_flying,
    input  logic [CHANNELS-1:0]  dn_odd_clusters,
    output logic [CHANNELS-1:0]  up_msg_flying,
    output logic [CHANNELS-1:0]  up_odd_clusters
);

    // shared link time, free running and allowed to wrap
    logic [TIME_WIDTH-1:0] link_time;

    always_ff @(posedge clk) begin
        if (reset) begin
            link_time <= '0;
        end else begin
            link_time <= link_time + 1'b1;
        end
    end

    for (genvar c = 0; c < CHANNELS; c++) begin : g_channel
        // upstream to downstream
        latency_lane u_lane_dn (
            .clk       (clk),
            .reset     (reset),
            .now       (link_time),
            .in_data   (up_in_data[c*DATA_WIDTH +: DATA_WIDTH]),
            .in_valid  (up_in_valid[c]),
            .in_ready  (up_in_ready[c]),
            .out_data  (dn_out_data[c*DATA_WIDTH +: DATA_WIDTH]),
            .out_valid (dn_out_valid[c]),
            .out_ready (dn_out_ready[c])
        );

        // downstream to upstream
        latency_lane u_lane_up (
            .clk       (clk),
            .reset     (reset),
            .now       (link_time),
            .in_data   (dn_in_data[c*DATA_WIDTH +: DATA_WIDTH]),
            .in_valid  (dn_in_valid[c]),
            .in_ready  (dn_in_ready[c]),
            .out_data  (up_out_data[c*DATA_WIDTH +: DATA_WIDTH]),
            .out_valid (up_out_valid[c]),
            .out_ready (up_out_ready[c])
        );
    end

    status_relay u_status_relay (
        .clk              (clk),
        .reset            (reset),
        .msg_flying_in    (dn_msg_flying),
        .odd_clusters_in  (dn_odd_clusters),
        .msg_flying_out   (up_msg_flying),
        .odd_clusters_out (up_odd_clusters)
    );

endmodule

/* hw/link_pkg.sv */
package link_pkg;

    // width of one channel word
    localparam int DATA_WIDTH = 32;

    // independent channels, each carrying words both ways
    localparam int CHANNELS = 2;

    // cycles from acceptance on one side to out_valid on the far side
    localparam int LINK_LATENCY = 4;

    // entries per lane buffer
    localparam int FIFO_DEPTH = 16;

    // link time counter and release stamps
    // compared by the sign of their difference, so wrap is harmless
    // as long as the latency stays far below half the range
    localparam int TIME_WIDTH = 16;

    // register stages between dn_* status inputs and up_* outputs
    localparam int STATUS_DELAY = 2;

    // one stored lane entry: data word plus its release stamp
    localparam int ENTRY_WIDTH = DATA_WIDTH + TIME_WIDTH;

    // pointer and occupancy widths for the lane FIFO
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int COUNT_WIDTH = PTR_WIDTH + 1;

    // flat bus widths at the top level
    localparam int BUS_WIDTH = DATA_WIDTH * CHANNELS;

    // the FIFO write and the time counter advance on the same edge,
    // so the stamp is taken relative to the next cycle's time
    localparam int STAMP_OFFSET = LINK_LATENCY + 1;

endpackage

/* hw/status_relay.sv */
`timescale 1ns/1ps

module status_relay
    import link_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [CHANNELS-1:0] msg_flying_in,
    input  logic [CHANNELS-1:0] odd_clusters_in,
    output logic [CHANNELS-1:0] msg_flying_out,
    output logic [CHANNELS-1:0] odd_clusters_out
);

    // first stage of the sideband crossing
    logic [CHANNELS-1:0] msg_flying_d;
    logic [CHANNELS-1:0] odd_clusters_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            msg_flying_d     <= '0;
            odd_clusters_d   <= '0;
            msg_flying_out   <= '0;
            odd_clusters_out <= '0;
        end else begin
            msg_flying_d     <= msg_flying_in;
            odd_clusters_d   <= odd_clusters_in;
            msg_flying_out   <= msg_flying_d;
            odd_clusters_out <= odd_clusters_d;
        end
    end

endmodule

/* test/link_checker.sv */
`timescale 1ns/1ps

module link_checker
    import link_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [BUS_WIDTH-1:0] up_in_data,
    input  logic [CHANNELS-1:0]  up_in_valid,
    input  logic [CHANNELS-1:0]  up_in_ready,
    input  logic [BUS_WIDTH-1:0] up_out_data,
    input  logic [CHANNELS-1:0]  up_out_valid,
    input  logic [CHANNELS-1:0]  up_out_ready,
    input  logic [BUS_WIDTH-1:0] dn_in_data,
    input  logic [CHANNELS-1:0]  dn_in_valid,
    input  logic [CHANNELS-1:0]  dn_in_ready,
    input  logic [BUS_WIDTH-1:0] dn_out_data,
    input  logic [CHANNELS-1:0]  dn_out_valid,
    input  logic [CHANNELS-1:0]  dn_out_ready,
    input  logic [CHANNELS-1:0]  dn_msg_flying,
    input  logic [CHANNELS-1:0]  dn_odd_clusters,
    input  logic [CHANNELS-1:0]  up_msg_flying,
    input  logic [CHANNELS-1:0]  up_odd_clusters,
    output int                   errors,
    output int                   pending
);

    localparam int LANES = 2 * CHANNELS;
    localparam int SLOTS = 2 * FIFO_DEPTH;

    // lanes below CHANNELS run up to down, the others down to up
    wire [LANES*DATA_WIDTH-1:0] in_data   = {dn_in_data, up_in_data};
    wire [LANES*DATA_WIDTH-1:0] out_data  = {up_out_data, dn_out_data};
    wire [LANES-1:0]            in_valid  = {dn_in_valid, up_in_valid};
    wire [LANES-1:0]            in_ready  = {dn_in_ready, up_in_ready};
    wire [LANES-1:0]            out_valid = {up_out_valid, dn_out_valid};
    wire [LANES-1:0]            out_ready = {up_out_ready, dn_out_ready};

    // words in flight per lane, kept as ring buffers
    logic [DATA_WIDTH-1:0] exp_data [LANES][SLOTS];
    int                    exp_cycle [LANES][SLOTS];
    int                    head [LANES];
    int                    fill [LANES];
    int                    last_pop [LANES];
    logic                  showing [LANES];
    logic [CHANNELS-1:0]   msg_hist [STATUS_DELAY];
    logic [CHANNELS-1:0]   odd_hist [STATUS_DELAY];
    int                    cycle;

    task automatic expect_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                                input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%0h got 0x%0h at cycle %0d",
                     name, expected, actual, cycle);
            errors = errors + 1;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s at cycle %0d", what, cycle);
        errors = errors + 1;
    endtask

    task automatic check_lane(input int l);
        string out_side;
        string in_side;
        int    due;
        out_side = (l < CHANNELS) ? "dn" : "up";
        in_side  = (l < CHANNELS) ? "up" : "dn";
        // ready drops only with a full lane
        expect_value($sformatf("%s_in_ready[%0d]", in_side, l % CHANNELS),
                     fill[l] != FIFO_DEPTH, in_ready[l]);
        if (out_valid[l] && fill[l] == 0) begin
            report_failure($sformatf("%s_out_valid[%0d] is high with no word in flight",
                                     out_side, l % CHANNELS));
        end else if (out_valid[l]) begin
            if (!showing[l]) begin
                // rises LINK_LATENCY edges after acceptance, or right after the previous pop
                due = exp_cycle[l][head[l]] + LINK_LATENCY + 1;
                if (last_pop[l] + 1 > due) begin
                    due = last_pop[l] + 1;
                end
                if (cycle != due) begin
                    report_failure($sformatf("%s_out_valid[%0d] rose for edge %0d, not edge %0d",
                                             out_side, l % CHANNELS, cycle, due));
                end
                showing[l] = 1'b1;
            end
            expect_value($sformatf("%s_out_data[%0d]", out_side, l % CHANNELS),
                         exp_data[l][head[l]], out_data[l*DATA_WIDTH +: DATA_WIDTH]);
            if (out_ready[l]) begin
                head[l]     = (head[l] + 1) % SLOTS;
                fill[l]     = fill[l] - 1;
                last_pop[l] = cycle;
                showing[l]  = 1'b0;
            end
        end else if (showing[l]) begin
            report_failure($sformatf("%s_out_valid[%0d] dropped before its handshake",
                                     out_side, l % CHANNELS));
            showing[l] = 1'b0;
        end
        if (in_valid[l] && in_ready[l]) begin
            exp_data[l][(head[l] + fill[l]) % SLOTS]  = in_data[l*DATA_WIDTH +: DATA_WIDTH];
            exp_cycle[l][(head[l] + fill[l]) % SLOTS] = cycle;
            fill[l] = fill[l] + 1;
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (reset) begin
            for (int l = 0; l < LANES; l++) begin
                head[l]     = 0;
                fill[l]     = 0;
                last_pop[l] = 0;
                showing[l]  = 1'b0;
            end
            msg_hist = '{default: '0};
            odd_hist = '{default: '0};
            errors   = 0;
        end else begin
            // status outputs trail the downstream inputs by the relay depth
            expect_value("up_msg_flying", msg_hist[STATUS_DELAY-1], up_msg_flying);
            expect_value("up_odd_clusters", odd_hist[STATUS_DELAY-1], up_odd_clusters);
            for (int s = STATUS_DELAY - 1; s > 0; s--) begin
                msg_hist[s] = msg_hist[s-1];
                odd_hist[s] = odd_hist[s-1];
            end
            msg_hist[0] = dn_msg_flying;
            odd_hist[0] = dn_odd_clusters;
            for (int l = 0; l < LANES; l++) begin
                check_lane(l);
            end
        end
        pending = 0;
        for (int l = 0; l < LANES; l++) begin
            pending = pending + fill[l];
        end
    end

endmodule

/* test/link_model_tb.sv */
`timescale 1ns/1ps

module link_model_tb
    import link_pkg::*;
();

    localparam int DIR_DOWN       = 0;
    localparam int DIR_UP         = 1;
    localparam int DIR_ALL        = 2;
    localparam int ROWS           = 11;
    localparam int TIMEOUT_CYCLES = ROWS * (LINK_LATENCY + FIFO_DEPTH + 10);

    logic                 clk = 1'b0;
    logic                 reset;
    logic [BUS_WIDTH-1:0] up_in_data;
    logic [CHANNELS-1:0]  up_in_valid;
    logic [CHANNELS-1:0]  up_in_ready;
    logic [BUS_WIDTH-1:0] up_out_data;
    logic [CHANNELS-1:0]  up_out_valid;
    logic [CHANNELS-1:0]  up_out_ready;
    logic [BUS_WIDTH-1:0] dn_in_data;
    logic [CHANNELS-1:0]  dn_in_valid;
    logic [CHANNELS-1:0]  dn_in_ready;
    logic [BUS_WIDTH-1:0] dn_out_data;
    logic [CHANNELS-1:0]  dn_out_valid;
    logic [CHANNELS-1:0]  dn_out_ready;
    logic [CHANNELS-1:0]  dn_msg_flying;
    logic [CHANNELS-1:0]  dn_odd_clusters;
    logic [CHANNELS-1:0]  up_msg_flying;
    logic [CHANNELS-1:0]  up_odd_clusters;
    int                   errors;
    int                   pending;
    int                   seed;
    int                   cycle_count;
    int                   tests_run;
    int                   tests_failed;
    int                   error_mark;

    // one row per lane run: test, direction, channel, first word, words, stall, status flags
    // the flags double as the expected up_* status two cycles later
    int                    row_test  [ROWS] = '{2, 2, 3, 3, 4, 4, 5, 6, 6, 6, 6};
    int                    row_dir   [ROWS] = '{0, 1, 1, 0, 0, 1, 2, 0, 0, 0, 0};
    int                    row_chan  [ROWS] = '{0, 1, 0, 1, 0, 1, 0, 0, 0, 0, 0};
    logic [DATA_WIDTH-1:0] row_data  [ROWS] = '{32'h1234_5678, 32'hcafe_0001, 32'ha5a5_0000,
                                                32'h5a5a_0000, 32'hf00d_0000, 32'hbeef_0000,
                                                32'h7700_0000, '0, '0, '0, '0};
    int                    row_words [ROWS] = '{1, 1, 8, 8, 20, 18, 6, 0, 0, 0, 0};
    int                    row_stall [ROWS] = '{0, 0, 0, 0, 30, 25, 0, 0, 0, 0, 0};
    logic [CHANNELS-1:0]   row_msg   [ROWS] = '{0, 0, 1, 0, 2, 3, 0, 1, 2, 3, 0};
    logic [CHANNELS-1:0]   row_odd   [ROWS] = '{0, 0, 0, 2, 1, 3, 0, 2, 1, 0, 3};
    string                 test_name [6]    = '{"reset state", "single word latency",
                                                "burst order", "back-pressure and full",
                                                "all lanes at once", "status relay delay"};

    link_model DUT (.*);

    link_checker u_link_checker (.*);

    always #50 clk = ~clk;

    // budget per row covers latency, a full lane and some margin
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the link stopped moving words", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic drive_word(input int dir, input int ch, input logic [DATA_WIDTH-1:0] word,
                              input logic valid);
        if (dir == DIR_DOWN) begin
            up_in_data[ch*DATA_WIDTH +: DATA_WIDTH] = word;
            up_in_valid[ch] = valid;
        end else begin
            dn_in_data[ch*DATA_WIDTH +: DATA_WIDTH] = word;
            dn_in_valid[ch] = valid;
        end
    endtask

    task automatic send_words(input int dir, input int ch, input logic [DATA_WIDTH-1:0] first,
                              input int count);
        logic [DATA_WIDTH-1:0] word;
        logic                  ready;
        int                    sent;
        word = first;
        sent = 0;
        while (sent < count) begin
            drive_word(dir, ch, word, 1'b1);
            // ready only moves on edges, so this is the value the next edge sees
            ready = (dir == DIR_DOWN) ? up_in_ready[ch] : dn_in_ready[ch];
            @(posedge clk);
            #1;
            if (ready) begin
                sent = sent + 1;
                word = $random(seed);
            end
        end
        drive_word(dir, ch, '0, 1'b0);
    endtask

    task automatic hold_ready(input int dir, input int ch, input int cycles);
        if (cycles > 0) begin
            if (dir == DIR_DOWN) begin
                dn_out_ready[ch] = 1'b0;
            end else begin
                up_out_ready[ch] = 1'b0;
            end
            repeat (cycles) @(posedge clk);
            #1;
            dn_out_ready[ch] = (dir == DIR_DOWN) ? 1'b1 : dn_out_ready[ch];
            up_out_ready[ch] = (dir == DIR_UP) ? 1'b1 : up_out_ready[ch];
        end
    endtask

    task automatic run_row(input int r);
        dn_msg_flying   = row_msg[r];
        dn_odd_clusters = row_odd[r];
        if (row_dir[r] == DIR_ALL) begin
            // every lane at once, each with its own pattern
            for (int c = 0; c < CHANNELS; c++) begin
                fork
                    automatic int ch = c;
                    send_words(DIR_DOWN, ch, row_data[r] + ch, row_words[r]);
                    send_words(DIR_UP, ch, ~row_data[r] - ch, row_words[r]);
                join_none
            end
            wait fork;
        end else if (row_words[r] > 0) begin
            fork
                send_words(row_dir[r], row_chan[r], row_data[r], row_words[r]);
                hold_ready(row_dir[r], row_chan[r], row_stall[r]);
            join
        end
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (STATUS_DELAY + 1) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input int id);
        tests_run = tests_run + 1;
        if (errors == error_mark) begin
            $display("test %0d %s: ok", id, test_name[id-1]);
        end else begin
            $display("test %0d %s: %0d errors", id, test_name[id-1], errors - error_mark);
            tests_failed = tests_failed + 1;
        end
        error_mark = errors;
    endtask

    initial begin
        seed            = 98543;
        reset           = 1'b1;
        up_in_data      = '0;
        up_in_valid     = '0;
        up_out_ready    = '1;
        dn_in_data      = '0;
        dn_in_valid     = '0;
        dn_out_ready    = '1;
        dn_msg_flying   = '0;
        dn_odd_clusters = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // idle values are checked on the first edges out of reset
        repeat (STATUS_DELAY + 1) @(posedge clk);
        #1;
        report_test(1);
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
            if (r == ROWS - 1 || row_test[r + 1] != row_test[r]) begin
                report_test(row_test[r]);
            end
        end
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/link_pkg.sv
hw/fwft_fifo.sv
hw/latency_lane.sv
hw/status_relay.sv
hw/link_model.sv
test/link_checker.sv
test/link_model_tb.sv
